/* arb_settings.svh */
`ifndef ARB_SETTINGS_SVH
`define ARB_SETTINGS_SVH

// requesters sharing the resource
`define ARB_N 16

// first tree level splits the requesters evenly
`define ARB_GROUP_NUM 4

// group width is ARB_N / ARB_GROUP_NUM
// each group and the group stage use
// the same thermometer arbiter width

`endif

/* arb_pkg.sv */
package arb_pkg;

   `include "arb_settings.svh"

   // one bit per requester
   // used for req, ack and grant
   typedef logic [`ARB_N-1:0] req_vec_t;

   // one bit per group for group request and group grant
   typedef logic [`ARB_GROUP_NUM-1:0] grp_vec_t;

   // binary index of a single requester
   typedef logic [$clog2(`ARB_N)-1:0] req_idx_t;

   // locked winner is kept as req_idx_t
   // grant vectors are one-hot or zero

endpackage

/* hs_pkg.sv */
package hs_pkg;

   // four-phase lock controller phases
   // idle   no ack high, tree grant may be taken
   // busy   one ack held until winner drops req
   typedef enum logic {
      idle = 1'b0,
      busy = 1'b1
   } hs_state_t;

   // ack rises one cycle after lock
   // ack falls one cycle after winner req falls

endpackage

/* arb_if.sv */
`timescale 1ns/1ps

// lock controller <-> arbiter tree
interface arb_if
   import arb_pkg::*;
();

   req_vec_t req;          // raw requests from the ports
   req_vec_t grant;        // one-hot tree grant in the same cycle as req
   logic     any_grant;    // at least one request present
   logic     priority_en;  // grant taken, move pointers

   modport ctrl (
      output req,
      output priority_en,
      input  grant,
      input  any_grant
   );

   modport arb (
      input  req,
      input  priority_en,
      output grant,
      output any_grant
   );

endinterface

/* thermo_rr_arbiter.sv */
`timescale 1ns/1ps

// round-robin arbiter on thermometer codes
// pointer only moves when priority_en says the grant was taken
module thermo_rr_arbiter #(
   parameter int width = 4
) (
   input  logic             clk,
   input  logic             arst_n,
   input  logic [width-1:0] request,
   input  logic             priority_en,
   output logic [width-1:0] grant,
   output logic             any_grant
);

   logic [width-1:0] pointer;       // ones above the last winner
   logic [width-1:0] masked_req;
   logic [width-1:0] thermo_req;
   logic [width-1:0] thermo_mask;
   logic [width-1:0] sel_code;
   logic [width-1:0] edge_mask;

   // bit i set when any of bits i..0 is set
   function automatic logic [width-1:0] thermo(input logic [width-1:0] v);
      logic [width-1:0] t;
      t[0] = v[0];
      for (int i = 1; i < width; i++) begin
         t[i] = t[i-1] | v[i];
      end
      return t;
   endfunction

   assign masked_req  = request & pointer;
   assign thermo_req  = thermo(request);
   assign thermo_mask = thermo(masked_req);

   // masked code wins when something above the last winner requests
   assign sel_code = thermo_mask[width-1] ? thermo_mask : thermo_req;

   assign edge_mask = {sel_code[width-2:0], 1'b0};
   assign grant     = sel_code ^ edge_mask;   // lowest set bit of the code
   assign any_grant = thermo_req[width-1];

   // index 0 first after reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pointer <= '1;
      end else if (priority_en) begin
         pointer <= edge_mask;   // bits above the granted index
      end
   end

endmodule

/* tree_arbiter.sv */
`timescale 1ns/1ps

`include "arb_settings.svh"

// two-level round robin
// member stage picks one per group and group stage picks the group
module tree_arbiter
   import arb_pkg::*;
(
   input  logic clk,
   input  logic arst_n,
   arb_if.arb   bus
);

   localparam int grp_num = `ARB_GROUP_NUM;
   localparam int grp_w   = `ARB_N / `ARB_GROUP_NUM;

   grp_vec_t   grp_req;                   // group has a pending request
   grp_vec_t   grp_grant;                 // winning group, one-hot
   grp_vec_t   mem_pen;                   // per-group pointer enable
   logic [grp_w-1:0] mem_grant [grp_num]; // member winner inside each group
   req_vec_t   grant_all;

   for (genvar g = 0; g < grp_num; g++) begin : g_member

      // only the taken group rotates its member pointer
      assign mem_pen[g] = bus.priority_en & grp_grant[g];

      thermo_rr_arbiter #(
         .width       (grp_w)
      ) i_member_arb (
         .clk         (clk),
         .arst_n      (arst_n),
         .request     (bus.req[g*grp_w +: grp_w]),
         .priority_en (mem_pen[g]),
         .grant       (mem_grant[g]),
         .any_grant   (grp_req[g])
      );

   end

   // second level over the group requests
   thermo_rr_arbiter #(
      .width       (grp_num)
   ) i_group_arb (
      .clk         (clk),
      .arst_n      (arst_n),
      .request     (grp_req),
      .priority_en (bus.priority_en),
      .grant       (grp_grant),
      .any_grant   (bus.any_grant)
   );

   // keep only the member grant of the winning group
   always_comb begin
      grant_all = '0;
      for (int g = 0; g < grp_num; g++) begin
         grant_all[g*grp_w +: grp_w] = mem_grant[g] & {grp_w{grp_grant[g]}};
      end
   end

   assign bus.grant = grant_all;

endmodule

/* req_ack_ctrl.sv */
`timescale 1ns/1ps

// four-phase req/ack lock
// takes one tree grant and holds its ack until the winner drops req
module req_ack_ctrl
   import arb_pkg::*;
   import hs_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  req_vec_t req,
   output req_vec_t ack,
   arb_if.ctrl      bus
);

   hs_state_t state;
   hs_state_t state_nxt;
   req_vec_t  ack_q;
   req_idx_t  win_idx;     // locked requester
   req_idx_t  grant_idx;   // tree grant as an index
   logic      lock;
   logic      unlock;

   // one-hot to binary, zero when nothing is set
   function automatic req_idx_t onehot_to_idx(input req_vec_t oh);
      req_idx_t idx;
      idx = '0;
      for (int i = 0; i < $bits(req_vec_t); i++) begin
         if (oh[i]) begin
            idx = req_idx_t'(i);
         end
      end
      return idx;
   endfunction

   // requests go to the tree unchanged
   assign bus.req = req;

   assign grant_idx = onehot_to_idx(bus.grant);

   // take a grant only while nothing is locked
   assign lock   = (state == idle) & bus.any_grant;
   assign unlock = (state == busy) & ~req[win_idx];   // winner lowered req

   // pointers move once per accepted grant
   assign bus.priority_en = lock;

   always_comb begin
      state_nxt = state;
      unique case (state)
         idle: begin
            if (lock) begin
               state_nxt = busy;
            end
         end
         busy: begin
            if (unlock) begin
               state_nxt = idle;
            end
         end
         default: state_nxt = idle;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= idle;
         ack_q   <= '0;
         win_idx <= '0;
      end else begin
         state <= state_nxt;
         if (lock) begin
            ack_q   <= bus.grant;   // one-hot so at most one ack
            win_idx <= grant_idx;
         end else if (unlock) begin
            ack_q <= '0;
         end
      end
   end

   assign ack = ack_q;

endmodule

/* rr_arbiter_top.sv */
`timescale 1ns/1ps

// 16-way round-robin arbiter with four-phase req/ack ports
module rr_arbiter_top
   import arb_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  req_vec_t req,
   output req_vec_t ack
);

   // lock controller to tree
   arb_if bus_if ();

   // four-phase lock and ack register
   req_ack_ctrl i_ctrl (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (req),
      .ack    (ack),
      .bus    (bus_if.ctrl)
   );

   // combinational two-level grant
   // pointers held in the tree
   tree_arbiter i_tree (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (bus_if.arb)
   );

endmodule

/* tb_rr_arbiter.sv */
`timescale 1ns/1ps

`include "arb_settings.svh"

// checks the 16-way arbiter against a two-level round-robin model
module tb_rr_arbiter
   import arb_pkg::*;
   import hs_pkg::*;
();

   localparam int grp_num    = `ARB_GROUP_NUM;
   localparam int grp_w      = `ARB_N / `ARB_GROUP_NUM;
   localparam int max_lines  = 64;
   localparam int wait_limit = 20;   // cycles per wait

   logic     clk = 1'b0;
   logic     arst_n;
   req_vec_t req;
   req_vec_t ack;

   logic [15:0] stim_mem [0:3*max_lines-1];   // request, hold, winner per line
   int          error_count;
   bit          aborted;
   hs_state_t   phase;          // handshake phase for messages only
   int          last_grp;       // -1 until the first grant
   int          last_mem [grp_num];
   req_vec_t    last_ack;       // ack of the previous line

   rr_arbiter_top i_dut (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (req),
      .ack    (ack)
   );

   always #20 clk = ~clk;

   task automatic report_error(input string msg);
      $display("ERR %0t: %s (%s phase)", $time, msg, phase.name());
      error_count++;
   endtask

   // reference pick by the round-robin rule with group first then member
   function automatic int model_pick(input req_vec_t vec);
      grp_vec_t greq;
      int       sel_g;
      int       sel_m;
      sel_g = -1;
      sel_m = -1;
      for (int g = 0; g < grp_num; g++) begin
         greq[g] = |vec[g*grp_w +: grp_w];
      end
      for (int g = last_grp + 1; g < grp_num; g++) begin
         if (greq[g] && sel_g < 0) begin
            sel_g = g;
         end
      end
      for (int g = 0; g < grp_num; g++) begin   // wrap around
         if (greq[g] && sel_g < 0) begin
            sel_g = g;
         end
      end
      if (sel_g < 0) begin
         return -1;
      end
      for (int m = last_mem[sel_g] + 1; m < grp_w; m++) begin
         if (vec[sel_g*grp_w + m] && sel_m < 0) begin
            sel_m = m;
         end
      end
      for (int m = 0; m < grp_w; m++) begin
         if (vec[sel_g*grp_w + m] && sel_m < 0) begin
            sel_m = m;
         end
      end
      return sel_g * grp_w + sel_m;
   endfunction

   function automatic int lowest_set_bit(input req_vec_t v);
      int idx;
      idx = -1;
      for (int i = 0; i < `ARB_N; i++) begin
         if (v[i] && idx < 0) begin
            idx = i;
         end
      end
      return idx;
   endfunction

   task automatic wait_ack_rise(input int who, output bit timed_out);
      int cycles;
      cycles    = 0;
      timed_out = 1'b0;
      do begin
         @(negedge clk);
         cycles++;
      end while (ack == '0 && cycles < wait_limit);
      if (ack == '0) begin
         $display("timeout: no ack for requester %0d after %0d cycles", who, wait_limit);
         error_count++;
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_ack_fall(input int who, input req_vec_t held, output bit timed_out);
      int cycles;
      cycles    = 0;
      timed_out = 1'b0;
      do begin
         @(negedge clk);
         cycles++;
         if (ack != '0 && ack != held) begin
            report_error($sformatf("ack %h rose while %0d was releasing", ack, who));
         end
      end while (ack != '0 && cycles < wait_limit);
      if (ack != '0) begin
         $display("timeout: ack of requester %0d still high %0d cycles after its req fell",
                  who, wait_limit);
         error_count++;
         timed_out = 1'b1;
      end
   endtask

   // one arbitration through request, grant, hold and release
   task automatic run_line(input int n, input req_vec_t vec, input int hold, input int exp_idx);
      req_vec_t exp_bit;
      req_vec_t held;
      int       model_idx;
      int       got_idx;
      bit       timed_out;
      exp_bit   = req_vec_t'(1) << exp_idx;
      model_idx = model_pick(vec);
      if (model_idx != exp_idx) begin
         report_error($sformatf("line %0d: model picks %0d, stim file says %0d",
                                n, model_idx, exp_idx));
      end
      // leftover requests were already arbitrated at the release edge
      if (req != '0 && (vec & ~last_ack) != req) begin
         $display("stim line %0d changes requests that are still pending", n);
         error_count++;
      end
      @(posedge clk);
      req <= vec;
      phase = idle;
      wait_ack_rise(exp_idx, timed_out);
      if (timed_out) begin
         aborted = 1'b1;
         return;
      end
      phase   = busy;
      held    = ack;
      got_idx = lowest_set_bit(ack);
      if ($countones(ack) != 1) begin
         report_error($sformatf("line %0d: ack %h is not one-hot", n, ack));
      end else if ((ack & req) == '0) begin
         report_error($sformatf("line %0d: ack %h without a request", n, ack));
      end else if (ack != exp_bit) begin
         report_error($sformatf("line %0d: requester %0d acked, expected %0d",
                                n, got_idx, exp_idx));
      end
      repeat (hold) begin
         @(negedge clk);
         if (ack != held) begin
            report_error($sformatf("line %0d: ack %h changed during hold, was %h",
                                   n, ack, held));
         end
      end
      @(posedge clk);
      req[got_idx] <= 1'b0;   // only the winner lets go
      wait_ack_fall(got_idx, held, timed_out);
      if (timed_out) begin
         aborted = 1'b1;
         return;
      end
      phase = idle;
      if (req == '0) begin
         repeat (2) begin
            @(negedge clk);
            if (ack != '0) begin
               report_error($sformatf("line %0d: ack %h with no request", n, ack));
            end
         end
      end
      last_grp = model_idx / grp_w;
      last_mem[model_idx / grp_w] = model_idx % grp_w;
      last_ack = held;
   endtask

   initial begin
      int n_line;
      error_count = 0;
      aborted     = 1'b0;
      phase       = idle;
      last_grp    = -1;
      last_ack    = '0;
      for (int g = 0; g < grp_num; g++) begin
         last_mem[g] = -1;
      end
      arst_n <= 1'b0;
      req    <= '0;
      $readmemh("rr_stim.txt", stim_mem);
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;

      // quiet bus after reset
      repeat (4) begin
         @(negedge clk);
         if (ack != '0) begin
            report_error($sformatf("ack %h after reset with no request", ack));
         end
      end

      n_line = 0;
      while (!aborted && n_line < max_lines && stim_mem[3*n_line] != '0) begin
         run_line(n_line, stim_mem[3*n_line], int'(stim_mem[3*n_line+1]),
                  int'(stim_mem[3*n_line+2]));
         n_line++;
      end
      if (n_line == 0) begin
         $display("no stimulus lines were read from rr_stim.txt");
         error_count++;
      end

      $display("stimulus lines: %0d, error count: %0d", n_line, error_count);
      if (error_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* rr_stim.txt */
// columns: request vector, hold cycles, expected winner index (all hex)
// a line of zeros ends the list
// all requesters, each winner raises req again once its ack is low
ffff 2 0
ffff 1 4
ffff 1 8
ffff 1 c
ffff 2 1
ffff 1 5
ffff 1 9
ffff 3 d
// winners now stay low, the rest drain in round-robin order
dfff 1 2
dffb 1 6
dfbb 1 a
dbbb 2 e
9bbb 1 3
9bb3 1 7
9b33 1 b
9333 1 f
1333 2 0
1332 1 4
1322 1 8
1222 1 c
0222 1 1
0220 1 5
0200 2 9
// group 1 alone, members rotate in index order
00f0 1 6
00f0 2 7
00f0 1 4
00f0 1 5
00f0 3 6
00b0 1 7
0030 1 4
0020 1 5
// groups 0 and 2 kept their member pointers while group 1 ran
0f0f 2 a
0b0f 1 2
0b0b 1 b
030b 1 3
0303 1 8
0203 1 0
0202 1 9
0002 2 1
// wrap between the outer groups, single requesters
8001 1 f
8001 2 0
8000 1 f
0010 4 4
4000 1 e
0000 0 0

/* flist.f */
+incdir+.
arb_pkg.sv
hs_pkg.sv
arb_if.sv
thermo_rr_arbiter.sv
tree_arbiter.sv
req_ack_ctrl.sv
rr_arbiter_top.sv
tb_rr_arbiter.sv

/* Makefile */
# Verilator build and run of the round-robin arbiter testbench
TOP := tb_rr_arbiter

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f flist.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
